//--- all.f
verilog/loopback_pkg.sv
verilog/two_entry_fifo.sv
verilog/pattern_gen.sv
verilog/response_checker.sv
verilog/loopback_echo.sv
verilog/loopback_test_node.sv
verilog/loopback_top.sv
test/loopback_monitor.sv
test/loopback_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --default-language 1800-2005 --top-module loopback_tb \
    -Mdir obj_dir -f all.f; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vloopback_tb > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error status"
  exit 1
fi
cat "$log"

if grep -q "Errors found" "$log"; then
  echo "FAILED"
  exit 1
fi

echo "PASSED"
exit 0

//--- test/loopback_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_monitor #(
  parameter int max_stall_words_p = 5
) (
  input  logic                                 clk_i
  ,input  logic                                 reset_i
  ,input  logic                                 en_i
  ,input  logic                                 error_i
  ,input  logic [loopback_pkg::count_width-1:0] sent_i
  ,input  logic [loopback_pkg::count_width-1:0] received_i
  ,input  logic [127:0]                         test_name_i
  ,input  logic [1:0]                           stall_mode_i
  ,input  logic                                 exp_error_i
  ,input  logic                                 active_i
  ,input  logic                                 done_i
  ,output logic [31:0]                          error_count_o
  ,output logic [31:0]                          test_count_o
  ,output logic [31:0]                          failed_count_o
);

  import loopback_pkg::*;

  logic                   reset_checked = 1'b0;
  logic                   active_d = 1'b0;
  logic                   en_phase = 1'b0;
  logic                   error_seen = 1'b0;
  logic                   hold_flagged = 1'b0;
  logic [count_width-1:0] sent_base = '0;
  logic [count_width-1:0] en_cycles = '0;
  logic [31:0]            test_errs = '0;
  logic [31:0]            error_total = '0;
  logic [31:0]            test_total = '0;
  logic [31:0]            failed_total = '0;

  assign error_count_o  = error_total;
  assign test_count_o   = test_total;
  assign failed_count_o = failed_total;

  // name is right aligned, zero bytes in front
  task automatic print_name();
    for (int i = 15; i >= 0; i--) begin
      if (test_name_i[i*8 +: 8] != 8'h00) begin
        $write("%c", test_name_i[i*8 +: 8]);
      end
    end
  endtask

  task automatic report_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    $write("ERROR ");
    print_name();
    $display(": %s expected %0d actual %0d", what, expected, actual);
    test_errs++;
  endtask

  task automatic report_text(input string what);
    $write("test ");
    print_name();
    $display(" failed: %s", what);
    test_errs++;
  endtask

  task automatic check_reset_state();
    logic [31:0] errs;
    errs = '0;
    if (error_i !== 1'b0) begin
      $display("ERROR reset_state: error_o expected 0 actual %0d", error_i);
      errs++;
    end
    if (sent_i !== '0) begin
      $display("ERROR reset_state: sent_o expected 0 actual %0d", sent_i);
      errs++;
    end
    if (received_i !== '0) begin
      $display("ERROR reset_state: received_o expected 0 actual %0d", received_i);
      errs++;
    end
    test_total++;
    if (errs == 0) begin
      $display("test reset_state: passed");
    end else begin
      $display("test reset_state: failed with %0d errors", errs);
      failed_total++;
    end
    error_total = error_total + errs;
  endtask

  task automatic finish_test();
    logic [count_width-1:0] rise;
    string                  msg;
    rise = sent_i - sent_base;
    // every request comes back once after the drain
    if (received_i !== sent_i) report_value("received_o", sent_i, received_i);
    if (error_i !== exp_error_i) report_value("error_o", {31'b0, exp_error_i}, {31'b0, error_i});
    if (en_phase && stall_mode_i == 2'd2 && rise > max_stall_words_p) begin
      $sformat(msg, "sent_o rose by %0d words during a held stall, limit %0d",
               rise, max_stall_words_p);
      report_text(msg);
    end
    // one word per enabled cycle when nothing stalls
    if (en_phase && stall_mode_i == 2'd0 && rise !== en_cycles) begin
      report_value("sent_o", sent_base + en_cycles, sent_i);
    end
    if (en_phase && stall_mode_i == 2'd1 && rise == 0) begin
      report_text("sent_o did not rise while en was high");
    end
    test_total++;
    $write("test ");
    print_name();
    if (test_errs == 0) begin
      $display(": passed, sent %0d received %0d", sent_i, received_i);
    end else begin
      $display(": failed with %0d errors", test_errs);
      failed_total++;
    end
    error_total = error_total + test_errs;
    test_errs   = '0;
  endtask

  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        check_reset_state();
      end
      // error flag is sticky
      if (error_i) begin
        error_seen = 1'b1;
      end else if (error_seen) begin
        error_seen = 1'b0;
        report_text("error_o fell without a reset");
      end
      if (active_i && !active_d) begin
        sent_base    = sent_i;
        en_phase     = en_i;
        en_cycles    = '0;
        hold_flagged = 1'b0;
      end else if (active_i && !en_phase && sent_i != sent_base && !hold_flagged) begin
        hold_flagged = 1'b1;
        report_text("sent_o changed while en was low");
      end
      if (active_i && en_i) en_cycles++;
      if (done_i) finish_test();
    end
    active_d = active_i;
  end

endmodule

`default_nettype wire

//--- test/loopback_stimulus.txt
# name cycles en stall_mode corrupt_cycle exp_error
# stall_mode 0 none, 1 random, 2 held high; corrupt_cycle 0 means no fault
idle 20 0 0 0 0
stream 60 1 0 0 0
random_stall 120 1 1 0 0
long_stall 30 1 2 0 0
enable_off 25 0 0 0 0
stream_again 40 1 0 0 0
fault 40 1 0 12 1
after_fault 50 1 0 0 1
random_after 60 1 1 0 1

//--- test/loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_tb;

  import loopback_pkg::*;

  localparam int clk_half_lp     = 50;
  localparam int reset_cycles_lp = 16;
  localparam int drain_cycles_lp = 24;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   en;
  logic                   stall;
  logic                   corrupt;
  logic                   error;
  logic [count_width-1:0] sent;
  logic [count_width-1:0] received;

  // phase info for the monitor
  logic [127:0]           test_name;
  logic [1:0]             stall_mode;
  logic                   exp_error;
  logic                   active;
  logic                   done;
  logic [31:0]            error_count;
  logic [31:0]            test_count;
  logic [31:0]            failed_count;

  // one entry per stimulus line
  logic [127:0]           name_q[$];
  int                     cycles_q[$];
  logic                   en_q[$];
  logic [1:0]             mode_q[$];
  int                     corrupt_q[$];
  logic                   exp_q[$];

  logic [31:0]            lcg_state = 32'd68;
  int                     run_cycles = 0;
  logic                   stim_ok;

  always #(clk_half_lp) clk = ~clk;

  loopback_top #(
    .channel_width_p(8)
    ,.num_channels_p(4)
  ) dut (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.en_i(en)
    ,.stall_i(stall)
    ,.corrupt_i(corrupt)
    ,.error_o(error)
    ,.sent_o(sent)
    ,.received_o(received)
  );

  loopback_monitor monitor (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.en_i(en)
    ,.error_i(error)
    ,.sent_i(sent)
    ,.received_i(received)
    ,.test_name_i(test_name)
    ,.stall_mode_i(stall_mode)
    ,.exp_error_i(exp_error)
    ,.active_i(active)
    ,.done_i(done)
    ,.error_count_o(error_count)
    ,.test_count_o(test_count)
    ,.failed_count_o(failed_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic load_stimulus(output logic ok);
    int               fd;
    int               n;
    int               cyc;
    int               en_v;
    int               mode_v;
    int               cor_v;
    int               exp_v;
    logic [127:0]     name_v;
    logic [8*120-1:0] line_buf;
    ok = 1'b0;
    fd = $fopen("test/loopback_stimulus.txt", "r");
    if (fd != 0) begin
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
        // comment and blank lines do not give six fields
        n = $sscanf(line_buf, "%s %d %d %d %d %d",
                    name_v, cyc, en_v, mode_v, cor_v, exp_v);
        if (n == 6) begin
          name_q.push_back(name_v);
          cycles_q.push_back(cyc);
          en_q.push_back(en_v != 0);
          mode_q.push_back(2'(mode_v));
          corrupt_q.push_back(cor_v);
          exp_q.push_back(exp_v != 0);
        end
        line_buf = '0;
      end
      $fclose(fd);
      ok = (name_q.size() > 0);
    end
  endtask

  task automatic run_test(input int idx);
    @(posedge clk);
    test_name  <= name_q[idx];
    stall_mode <= mode_q[idx];
    exp_error  <= exp_q[idx];
    active     <= 1'b1;
    for (int cyc = 1; cyc <= cycles_q[idx]; cyc++) begin
      lcg_state = lcg_next(lcg_state);
      en      <= en_q[idx];
      corrupt <= (cyc == corrupt_q[idx]);
      if (mode_q[idx] == 2'd1) begin
        stall <= lcg_state[16];
      end else begin
        stall <= (mode_q[idx] == 2'd2);
      end
      @(posedge clk);
    end
    // drain so that received catches up with sent
    active  <= 1'b0;
    en      <= 1'b0;
    stall   <= 1'b0;
    corrupt <= 1'b0;
    repeat (drain_cycles_lp) @(posedge clk);
    done <= 1'b1;
    @(posedge clk);
    done <= 1'b0;
  endtask

  initial begin
    reset      <= 1'b1;
    en         <= 1'b0;
    stall      <= 1'b0;
    corrupt    <= 1'b0;
    test_name  <= '0;
    stall_mode <= 2'd0;
    exp_error  <= 1'b0;
    active     <= 1'b0;
    done       <= 1'b0;
    load_stimulus(stim_ok);
    if (!stim_ok) begin
      $display("could not read any test from test/loopback_stimulus.txt");
      $display("Errors found");
      $finish;
    end else begin
      run_cycles = reset_cycles_lp;
      foreach (cycles_q[i]) run_cycles += cycles_q[i] + drain_cycles_lp + 2;
      repeat (reset_cycles_lp) @(posedge clk);
      reset <= 1'b0;
      foreach (name_q[i]) run_test(i);
      @(posedge clk);
      $display("%0d tests, %0d failed, %0d errors", test_count, failed_count, error_count);
      if (error_count == 0 && failed_count == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

  // watchdog at twice the expected run length
  initial begin
    wait (run_cycles > 0);
    repeat (run_cycles * 2) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", run_cycles * 2);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/loopback_echo.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_echo #(
  parameter int channel_width_p = loopback_pkg::default_channel_width
  ,parameter int num_channels_p  = loopback_pkg::default_num_channels
  ,localparam int word_width_lp  = channel_width_p * num_channels_p
) (
  input  logic                     clk_i
  ,input  logic                     reset_i
  ,input  logic                     stall_i
  ,input  logic                     corrupt_i
  ,input  logic                     req_v_i
  ,input  logic [word_width_lp-1:0] req_data_i
  ,output logic                     req_ready_o
  ,output logic                     resp_v_o
  ,output logic [word_width_lp-1:0] resp_data_o
  ,input  logic                     resp_ready_i
);

  logic                     req_in_v;
  logic [word_width_lp-1:0] req_in_data;
  logic                     move_v;
  logic                     move;
  logic                     resp_out_ready;
  logic                     resp_out_v;
  logic [word_width_lp-1:0] resp_out_data;

  two_entry_fifo #(.width_p(word_width_lp)) req_in_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.v_i(req_v_i)
    ,.data_i(req_data_i)
    ,.ready_o(req_ready_o)
    ,.v_o(req_in_v)
    ,.data_o(req_in_data)
    ,.yumi_i(move)
  );

  // request turns into a response with bit 0 flipped on fault
  assign move_v        = req_in_v & ~stall_i;
  assign move          = move_v & resp_out_ready;
  assign resp_out_data = req_in_data ^ word_width_lp'(corrupt_i);

  two_entry_fifo #(.width_p(word_width_lp)) resp_out_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.v_i(move_v)
    ,.data_i(resp_out_data)
    ,.ready_o(resp_out_ready)
    ,.v_o(resp_out_v)
    ,.data_o(resp_data_o)
    ,.yumi_i(resp_v_o & resp_ready_i)
  );

  // no responses go out during a stall
  assign resp_v_o = resp_out_v & ~stall_i;

endmodule

`default_nettype wire

//--- verilog/loopback_pkg.sv
`default_nettype none

package loopback_pkg;

  // default shape of one pattern word
  parameter int default_channel_width = 8;
  parameter int default_num_channels  = 4;

  // sent and received counters
  parameter int count_width = 32;

  // response checker progress
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_error
  } checker_state_e;

endpackage

`default_nettype wire

//--- verilog/loopback_test_node.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_test_node #(
  parameter int channel_width_p = loopback_pkg::default_channel_width
  ,parameter int num_channels_p  = loopback_pkg::default_num_channels
  ,localparam int word_width_lp  = channel_width_p * num_channels_p
) (
  input  logic                                 clk_i
  ,input  logic                                 reset_i
  ,input  logic                                 en_i
  ,input  logic                                 req_ready_i
  ,input  logic                                 resp_v_i
  ,input  logic [word_width_lp-1:0]             resp_data_i
  ,output logic                                 req_v_o
  ,output logic [word_width_lp-1:0]             req_data_o
  ,output logic                                 resp_ready_o
  ,output logic                                 error_o
  ,output logic [loopback_pkg::count_width-1:0] sent_o
  ,output logic [loopback_pkg::count_width-1:0] received_o
);

  import loopback_pkg::*;

  logic [word_width_lp-1:0] gen_data;
  logic                     req_out_ready;
  logic                     issue;
  logic                     resp_in_v;
  logic [word_width_lp-1:0] resp_in_data;
  logic                     resp_in_yumi;

  // a word issues whenever enabled and the buffer has room
  assign issue = en_i & req_out_ready;

  pattern_gen #(
    .channel_width_p(channel_width_p)
    ,.num_channels_p(num_channels_p)
  ) gen_out (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.yumi_i(issue)
    ,.data_o(gen_data)
  );

  two_entry_fifo #(.width_p(word_width_lp)) req_out_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.v_i(en_i)
    ,.data_i(gen_data)
    ,.ready_o(req_out_ready)
    ,.v_o(req_v_o)
    ,.data_o(req_data_o)
    ,.yumi_i(req_v_o & req_ready_i)
  );

  two_entry_fifo #(.width_p(word_width_lp)) resp_in_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.v_i(resp_v_i)
    ,.data_i(resp_data_i)
    ,.ready_o(resp_ready_o)
    ,.v_o(resp_in_v)
    ,.data_o(resp_in_data)
    ,.yumi_i(resp_in_yumi)
  );

  response_checker #(
    .channel_width_p(channel_width_p)
    ,.num_channels_p(num_channels_p)
  ) resp_checker (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.resp_v_i(resp_in_v)
    ,.resp_data_i(resp_in_data)
    ,.resp_yumi_o(resp_in_yumi)
    ,.error_o(error_o)
    ,.received_o(received_o)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sent_o <= '0;
    end else if (issue) begin
      sent_o <= sent_o + count_width'(1);
    end
  end

  // a response never arrives before its request left
  assert property (@(posedge clk_i) disable iff (reset_i) received_o <= sent_o);

endmodule

`default_nettype wire

//--- verilog/loopback_top.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_top #(
  parameter int channel_width_p = loopback_pkg::default_channel_width
  ,parameter int num_channels_p  = loopback_pkg::default_num_channels
  ,localparam int word_width_lp  = channel_width_p * num_channels_p
) (
  input  logic                                 clk_i
  ,input  logic                                 reset_i
  ,input  logic                                 en_i
  ,input  logic                                 stall_i
  ,input  logic                                 corrupt_i
  ,output logic                                 error_o
  ,output logic [loopback_pkg::count_width-1:0] sent_o
  ,output logic [loopback_pkg::count_width-1:0] received_o
);

  // request path
  logic                     req_v;
  logic [word_width_lp-1:0] req_data;
  logic                     req_ready;

  // response path
  logic                     resp_v;
  logic [word_width_lp-1:0] resp_data;
  logic                     resp_ready;

  loopback_test_node #(
    .channel_width_p(channel_width_p)
    ,.num_channels_p(num_channels_p)
  ) node (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.en_i(en_i)
    ,.req_ready_i(req_ready)
    ,.resp_v_i(resp_v)
    ,.resp_data_i(resp_data)
    ,.req_v_o(req_v)
    ,.req_data_o(req_data)
    ,.resp_ready_o(resp_ready)
    ,.error_o(error_o)
    ,.sent_o(sent_o)
    ,.received_o(received_o)
  );

  loopback_echo #(
    .channel_width_p(channel_width_p)
    ,.num_channels_p(num_channels_p)
  ) echo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.stall_i(stall_i)
    ,.corrupt_i(corrupt_i)
    ,.req_v_i(req_v)
    ,.req_data_i(req_data)
    ,.req_ready_o(req_ready)
    ,.resp_v_o(resp_v)
    ,.resp_data_o(resp_data)
    ,.resp_ready_i(resp_ready)
  );

endmodule

`default_nettype wire

//--- verilog/pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_gen #(
  parameter int channel_width_p = loopback_pkg::default_channel_width
  ,parameter int num_channels_p  = loopback_pkg::default_num_channels
  ,localparam int word_width_lp  = channel_width_p * num_channels_p
) (
  input  logic                     clk_i
  ,input  logic                     reset_i
  ,input  logic                     yumi_i
  ,output logic [word_width_lp-1:0] data_o
);

  localparam logic [channel_width_p-1:0] step_lp = channel_width_p'(num_channels_p);

  logic [channel_width_p-1:0] chan_r [num_channels_p];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int c = 0; c < num_channels_p; c++) begin
        chan_r[c] <= channel_width_p'(c);
      end
    end else if (yumi_i) begin
      // wraps at the channel width
      for (int c = 0; c < num_channels_p; c++) begin
        chan_r[c] <= chan_r[c] + step_lp;
      end
    end
  end

  // channel 0 in the low bits
  always_comb begin
    for (int c = 0; c < num_channels_p; c++) begin
      data_o[c*channel_width_p +: channel_width_p] = chan_r[c];
    end
  end

endmodule

`default_nettype wire

//--- verilog/response_checker.sv
`timescale 1ns/1ps
`default_nettype none

module response_checker #(
  parameter int channel_width_p = loopback_pkg::default_channel_width
  ,parameter int num_channels_p  = loopback_pkg::default_num_channels
  ,localparam int word_width_lp  = channel_width_p * num_channels_p
) (
  input  logic                                 clk_i
  ,input  logic                                 reset_i
  ,input  logic                                 resp_v_i
  ,input  logic [word_width_lp-1:0]             resp_data_i
  ,output logic                                 resp_yumi_o
  ,output logic                                 error_o
  ,output logic [loopback_pkg::count_width-1:0] received_o
);

  import loopback_pkg::*;

  checker_state_e           state_r;
  checker_state_e           state_n;
  logic [word_width_lp-1:0] expected;
  logic                     mismatch;

  // expected stream steps once per response
  pattern_gen #(
    .channel_width_p(channel_width_p)
    ,.num_channels_p(num_channels_p)
  ) gen_check (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.yumi_i(resp_v_i)
    ,.data_o(expected)
  );

  // always accepts
  assign resp_yumi_o = resp_v_i;
  assign mismatch    = resp_v_i & (resp_data_i != expected);
  assign error_o     = (state_r == st_error);

  always_comb begin
    state_n = state_r;
    if (mismatch) begin
      state_n = st_error;
    end else if (resp_v_i && state_r == st_idle) begin
      state_n = st_run;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= st_idle;
      received_o <= '0;
    end else begin
      state_r <= state_n;
      if (resp_v_i) received_o <= received_o + count_width'(1);
    end
  end

  // error is sticky until reset
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == st_error) |=> (state_r == st_error));

endmodule

`default_nettype wire

//--- verilog/two_entry_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module two_entry_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i
  ,input  logic               reset_i
  ,input  logic               v_i
  ,input  logic [width_p-1:0] data_i
  ,output logic               ready_o
  ,output logic               v_o
  ,output logic [width_p-1:0] data_o
  ,input  logic               yumi_i
);

  logic [width_p-1:0] mem_r [2];
  logic               rd_ptr_r;
  logic               wr_ptr_r;
  logic               full_r;
  logic               empty_r;
  logic               enq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ~full_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (enq) wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i) rd_ptr_r <= ~rd_ptr_r;
      // one left and popped without refill
      empty_r <= (empty_r & ~enq) | (~full_r & yumi_i & ~enq);
      full_r  <= (~empty_r & enq & ~yumi_i) | (full_r & ~yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wr_ptr_r] <= data_i;
  end

  // consumer only takes what is presented
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

  // no push while full keeps the presented word until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(data_o)));

endmodule

`default_nettype wire
